// File: hdl/pid_settings.svh
`ifndef PID_SETTINGS_SVH
`define PID_SETTINGS_SVH

////////////////////////////////////////
// channel and source counts
////////////////////////////////////////

// channel pipelines, one per dac output
`define N_CHAN 8

// adc sources, 0-3 on bus a and 4-7 on bus b
`define N_ADC 8

// channel or source index width, wide enough to hold invalid selections
`define W_CHAN_SEL 4

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// adc samples and dac codes
`define W_DATA 16

// setpoint and coefficients
`define W_COEF 16

// p+i sum and integral
`define W_SUM 40

// oversample exponent, up to 2^7 samples
`define W_OSM 3

// output right shift amount
`define W_RS 5

////////////////////////////////////////
// dac serial frame
////////////////////////////////////////

// bits per dac frame, two clock cycles per bit
`define W_FRAME 32

`endif

// File: hdl/pid_cfg_pkg.sv
`include "pid_settings.svh"

package pid_cfg_pkg;

	// host register map
	// address selects the setting, cfg_chan selects the channel
	typedef enum logic [7:0] {
		chan_activate = 8'h00,
		src_sel       = 8'h01,
		osf_osm       = 8'h02,
		pid_setpoint  = 8'h10,
		pid_p_coef    = 8'h11,
		pid_i_coef    = 8'h12,
		pid_lock_en   = 8'h13,
		opp_min       = 8'h20,
		opp_max       = 8'h21,
		opp_init      = 8'h22,
		opp_rs        = 8'h23
	} cfg_addr_t;

	// two's complement adc sample, also the averaged mean
	typedef logic signed [`W_DATA-1:0] sample_t;

	// setpoint and p/i coefficients
	// signed so that negative gain inverts the loop
	typedef logic signed [`W_COEF-1:0] coef_t;

endpackage

// File: hdl/dac_pkg.sv
`include "pid_settings.svh"

package dac_pkg;

	// unsigned dac8568 output code
	typedef logic [`W_DATA-1:0] dac_code_t;

	// dac8568 command nibble
	// only write and update channel is issued by this design
	typedef enum logic [3:0] {
		dac_cmd_write_input      = 4'h0,
		dac_cmd_update           = 4'h1,
		dac_cmd_write_update_all = 4'h2,
		dac_cmd_write_update     = 4'h3
	} dac_cmd_t;

	// frame fields, msb first on the wire
	typedef struct packed {
		logic [3:0] prefix;
		dac_cmd_t   cmd;
		logic [3:0] addr;
		dac_code_t  data;
		logic [3:0] feature;
	} dac_fields_t;

	// same 32 bits, built by field and shifted as a raw word
	typedef union packed {
		dac_fields_t          fields;
		logic [`W_FRAME-1:0] raw;
	} dac_frame_u;

endpackage

// File: hdl/chan_router.sv
`include "pid_settings.svh"

module chan_router (
	input  logic                       clk50_in,
	input  logic                       sys_reset,
	input  logic                       cfg_write,
	input  pid_cfg_pkg::cfg_addr_t     cfg_addr,
	input  logic [`W_CHAN_SEL-1:0]     cfg_chan,
	input  logic [31:0]                cfg_data,
	input  pid_cfg_pkg::sample_t       adc_data_a,
	input  pid_cfg_pkg::sample_t       adc_data_b,
	input  logic [`N_ADC-1:0]          adc_valid,
	output pid_cfg_pkg::sample_t       chan_sample [`N_CHAN],
	output logic [`N_CHAN-1:0]         chan_valid,
	output logic [`W_OSM-1:0]          chan_osm [`N_CHAN],
	output pid_cfg_pkg::coef_t         chan_setpoint [`N_CHAN],
	output pid_cfg_pkg::coef_t         chan_p_coef [`N_CHAN],
	output pid_cfg_pkg::coef_t         chan_i_coef [`N_CHAN],
	output logic [`N_CHAN-1:0]         chan_lock_en,
	output dac_pkg::dac_code_t         chan_min [`N_CHAN],
	output dac_pkg::dac_code_t         chan_max [`N_CHAN],
	output dac_pkg::dac_code_t         chan_init [`N_CHAN],
	output logic [`W_RS-1:0]           chan_rs [`N_CHAN]
);

	localparam int W_IDX = $clog2(`N_CHAN);
	localparam int W_ASEL = $clog2(`N_ADC);

	logic [`N_CHAN-1:0] activate;
	logic [`W_CHAN_SEL-1:0] src [`N_CHAN];
	logic [W_IDX-1:0] idx;

	// channel index into the register arrays
	assign idx = cfg_chan[W_IDX-1:0];

	////////////////////////////////////////
	// host register file
	////////////////////////////////////////

	// out of range channels and unknown addresses fall through
	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			activate <= '0;
			chan_lock_en <= '0;
			for (int i = 0; i < `N_CHAN; i++) begin
				src[i] <= '0;
				chan_osm[i] <= '0;
				chan_setpoint[i] <= '0;
				chan_p_coef[i] <= '0;
				chan_i_coef[i] <= '0;
				chan_min[i] <= '0;
				chan_max[i] <= '0;
				chan_init[i] <= '0;
				chan_rs[i] <= '0;
			end
		end else if (cfg_write && cfg_chan < `N_CHAN) begin
			case (cfg_addr)
				pid_cfg_pkg::chan_activate: activate[idx] <= cfg_data[0];
				pid_cfg_pkg::src_sel:       src[idx] <= cfg_data[`W_CHAN_SEL-1:0];
				pid_cfg_pkg::osf_osm:       chan_osm[idx] <= cfg_data[`W_OSM-1:0];
				pid_cfg_pkg::pid_setpoint:  chan_setpoint[idx] <= cfg_data[`W_COEF-1:0];
				pid_cfg_pkg::pid_p_coef:    chan_p_coef[idx] <= cfg_data[`W_COEF-1:0];
				pid_cfg_pkg::pid_i_coef:    chan_i_coef[idx] <= cfg_data[`W_COEF-1:0];
				pid_cfg_pkg::pid_lock_en:   chan_lock_en[idx] <= cfg_data[0];
				pid_cfg_pkg::opp_min:       chan_min[idx] <= cfg_data[`W_DATA-1:0];
				pid_cfg_pkg::opp_max:       chan_max[idx] <= cfg_data[`W_DATA-1:0];
				pid_cfg_pkg::opp_init:      chan_init[idx] <= cfg_data[`W_DATA-1:0];
				pid_cfg_pkg::opp_rs:        chan_rs[idx] <= cfg_data[`W_RS-1:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// sample routing
	////////////////////////////////////////

	for (genvar i = 0; i < `N_CHAN; i++) begin : g_route
		logic enable;

		// active and pointing at a real source
		assign enable = activate[i] && (src[i] < `N_ADC);
		// lower half of the sources share bus a
		assign chan_sample[i] = (src[i] < `N_ADC / 2) ? adc_data_a : adc_data_b;
		// strobe of the selected source, masked when disabled
		assign chan_valid[i] = enable && adc_valid[src[i][W_ASEL-1:0]];
	end

endmodule

// File: hdl/pid_channel.sv
`include "pid_settings.svh"

module pid_channel (
	input  logic                   clk50_in,
	input  logic                   sys_reset,
	input  pid_cfg_pkg::sample_t   sample,
	input  logic                   sample_valid,
	input  logic [`W_OSM-1:0]      osm,
	input  pid_cfg_pkg::coef_t     setpoint,
	input  pid_cfg_pkg::coef_t     p_coef,
	input  pid_cfg_pkg::coef_t     i_coef,
	input  logic                   lock_en,
	input  dac_pkg::dac_code_t     code_min,
	input  dac_pkg::dac_code_t     code_max,
	input  dac_pkg::dac_code_t     code_init,
	input  logic [`W_RS-1:0]       rs,
	output dac_pkg::dac_code_t     code,
	output logic                   code_valid
);

	// largest exponent, also the sample counter width
	localparam int OSM_MAX = (1 << `W_OSM) - 1;
	localparam int W_ACC = `W_DATA + OSM_MAX;
	localparam int W_ERR = `W_DATA + 1;
	localparam int W_SUM = `W_SUM;

	logic [OSM_MAX-1:0] cnt;
	logic last;
	logic signed [W_ACC-1:0] acc;
	logic signed [W_ACC-1:0] acc_next;
	pid_cfg_pkg::sample_t mean;
	logic mean_valid;
	logic signed [W_ERR-1:0] err;
	logic signed [W_ERR-1:0] err_q;
	logic signed [W_SUM-1:0] integ;
	logic signed [W_SUM-1:0] sum;
	logic signed [W_SUM-1:0] pre;
	logic signed [W_SUM-1:0] init_ext;
	logic signed [W_SUM-1:0] lo;
	logic signed [W_SUM-1:0] hi;
	logic v2;
	logic v3;
	logic v4;

	////////////////////////////////////////
	// stage 1 oversample
	////////////////////////////////////////

	// running sum including the sample on the bus
	assign acc_next = acc + W_ACC'(sample);
	assign last = cnt == OSM_MAX'((1 << osm) - 1);

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			cnt <= '0;
			acc <= '0;
			mean_valid <= 1'b0;
		end else begin
			mean_valid <= sample_valid && last;
			if (sample_valid) begin
				// group complete, start the next one from zero
				if (last) begin
					cnt <= '0;
					acc <= '0;
				end else begin
					cnt <= cnt + 1'b1;
					acc <= acc_next;
				end
			end
		end
	end

	// mean of 2^osm samples, arithmetic shift keeps the sign
	always_ff @(posedge clk50_in) begin
		if (sample_valid && last)
			mean <= pid_cfg_pkg::sample_t'(acc_next >>> osm);
	end

	////////////////////////////////////////
	// stage 2 error and integral
	////////////////////////////////////////

	// one extra bit so full scale error cannot wrap
	assign err = W_ERR'(setpoint) - W_ERR'(mean);

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			v2 <= 1'b0;
			integ <= '0;
		end else begin
			v2 <= mean_valid;
			// unlocked loop holds no history
			if (!lock_en)
				integ <= '0;
			else if (mean_valid)
				integ <= integ + W_SUM'(err);
		end
	end

	always_ff @(posedge clk50_in) begin
		if (mean_valid)
			err_q <= err;
	end

	////////////////////////////////////////
	// stage 3 p+i sum
	////////////////////////////////////////

	// integ already holds this group's error
	always_ff @(posedge clk50_in) begin
		if (v2)
			sum <= W_SUM'(p_coef) * W_SUM'(err_q) + W_SUM'(i_coef) * integ;
	end

	////////////////////////////////////////
	// stage 4 shift, offset, clamp
	////////////////////////////////////////

	// bounds and offset as positive values in the sum width
	assign init_ext = {{(W_SUM - `W_DATA){1'b0}}, code_init};
	assign lo = {{(W_SUM - `W_DATA){1'b0}}, code_min};
	assign hi = {{(W_SUM - `W_DATA){1'b0}}, code_max};

	always_ff @(posedge clk50_in) begin
		if (v3)
			pre <= init_ext + (sum >>> rs);
	end

	// negative results land below lo and clamp to min
	always_ff @(posedge clk50_in) begin
		if (v4) begin
			if (!lock_en)
				code <= code_init;
			else if (pre < lo)
				code <= code_min;
			else if (pre > hi)
				code <= code_max;
			else
				code <= pre[`W_DATA-1:0];
		end
	end

	// valid chain, four edges behind the last accepted sample
	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			v3 <= 1'b0;
			v4 <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			v3 <= v2;
			v4 <= v3;
			code_valid <= v4;
		end
	end

endmodule

// File: hdl/dac_instr_queue.sv
`include "pid_settings.svh"

module dac_instr_queue (
	input  logic                     clk50_in,
	input  logic                     sys_reset,
	input  dac_pkg::dac_code_t       code [`N_CHAN],
	input  logic [`N_CHAN-1:0]       code_valid,
	input  logic                     serial_done,
	output logic                     issue,
	output dac_pkg::dac_code_t       issue_code,
	output logic [`W_CHAN_SEL-1:0]   issue_chan
);

	localparam int W_IDX = $clog2(`N_CHAN);

	logic [`N_CHAN-1:0] pending;
	dac_pkg::dac_code_t value [`N_CHAN];
	logic busy;
	logic idle;
	logic [`N_CHAN-1:0] avail;
	logic [W_IDX-1:0] sel;
	dac_pkg::dac_code_t sel_code;

	// a value arriving this cycle counts as pending
	assign avail = pending | code_valid;
	// the issue pulse itself marks the driver busy for one cycle
	assign idle = !busy && !issue;

	// lowest index wins
	always_comb begin
		sel = '0;
		for (int i = `N_CHAN - 1; i >= 0; i--) begin
			if (avail[i])
				sel = i[W_IDX-1:0];
		end
	end

	// fresh value bypasses the stored copy
	assign sel_code = code_valid[sel] ? code[sel] : value[sel];

	always_ff @(posedge clk50_in) begin
		for (int i = 0; i < `N_CHAN; i++) begin
			if (code_valid[i])
				value[i] <= code[i];
		end
		if (idle && |avail) begin
			issue_code <= sel_code;
			issue_chan <= {{(`W_CHAN_SEL - W_IDX){1'b0}}, sel};
		end
	end

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			pending <= '0;
			busy <= 1'b0;
			issue <= 1'b0;
		end else begin
			issue <= idle && |avail;
			if (serial_done)
				busy <= 1'b0;
			else if (issue)
				busy <= 1'b1;
			// newer values overwrite, never block upstream
			pending <= pending | code_valid;
			// the issued channel leaves the queue
			if (idle && |avail)
				pending[sel] <= 1'b0;
		end
	end

endmodule

// File: hdl/dac_serial.sv
`include "pid_settings.svh"

module dac_serial (
	input  logic                     clk50_in,
	input  logic                     sys_reset,
	input  logic                     issue,
	input  dac_pkg::dac_code_t       issue_code,
	input  logic [`W_CHAN_SEL-1:0]   issue_chan,
	output logic                     sync,
	output logic                     sclk,
	output logic                     din,
	output logic                     done
);

	// two cycles per bit
	localparam int W_CNT = $clog2(2 * `W_FRAME);

	dac_pkg::dac_frame_u frame;
	logic [`W_FRAME-1:0] shift;
	logic [W_CNT-1:0] cnt;
	logic active;
	logic frame_end;
	logic end_q;

	// write and update the addressed channel
	always_comb begin
		frame.fields.prefix = '0;
		frame.fields.cmd = dac_pkg::dac_cmd_write_update;
		frame.fields.addr = issue_chan;
		frame.fields.data = issue_code;
		frame.fields.feature = '0;
	end

	// msb of the shifter is the wire
	assign din = shift[`W_FRAME-1];
	// last low half of the last bit
	assign frame_end = active && cnt == W_CNT'(2 * `W_FRAME - 1);

	////////////////////////////////////////
	// frame sequencer
	////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			active <= 1'b0;
			cnt <= '0;
			shift <= '0;
			sync <= 1'b1;
			sclk <= 1'b0;
		end else if (!active) begin
			// start, first bit goes out with sclk high
			if (issue) begin
				active <= 1'b1;
				cnt <= '0;
				shift <= frame.raw;
				sync <= 1'b0;
				sclk <= 1'b1;
			end
		end else begin
			cnt <= cnt + 1'b1;
			if (!cnt[0]) begin
				// high half done, din holds while the dac samples
				sclk <= 1'b0;
			end else if (frame_end) begin
				// the final shift leaves the wire low
				active <= 1'b0;
				sync <= 1'b1;
				shift <= shift << 1;
			end else begin
				sclk <= 1'b1;
				shift <= shift << 1;
			end
		end
	end

	// done one cycle after sync rises
	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			end_q <= 1'b0;
			done <= 1'b0;
		end else begin
			end_q <= frame_end;
			done <= end_q;
		end
	end

endmodule

// File: hdl/pid_controller.sv
`include "pid_settings.svh"

module pid_controller (
	input  logic                       clk50_in,
	input  logic                       sys_reset,
	input  logic                       cfg_write,
	input  pid_cfg_pkg::cfg_addr_t     cfg_addr,
	input  logic [`W_CHAN_SEL-1:0]     cfg_chan,
	input  logic [31:0]                cfg_data,
	input  pid_cfg_pkg::sample_t       adc_data_a,
	input  pid_cfg_pkg::sample_t       adc_data_b,
	input  logic [`N_ADC-1:0]          adc_valid,
	output logic                       dac_sync,
	output logic                       dac_sclk,
	output logic                       dac_din
);

	// router to channels
	pid_cfg_pkg::sample_t chan_sample [`N_CHAN];
	logic [`N_CHAN-1:0] chan_valid;
	logic [`W_OSM-1:0] chan_osm [`N_CHAN];
	pid_cfg_pkg::coef_t chan_setpoint [`N_CHAN];
	pid_cfg_pkg::coef_t chan_p_coef [`N_CHAN];
	pid_cfg_pkg::coef_t chan_i_coef [`N_CHAN];
	logic [`N_CHAN-1:0] chan_lock_en;
	dac_pkg::dac_code_t chan_min [`N_CHAN];
	dac_pkg::dac_code_t chan_max [`N_CHAN];
	dac_pkg::dac_code_t chan_init [`N_CHAN];
	logic [`W_RS-1:0] chan_rs [`N_CHAN];

	// channels to queue
	dac_pkg::dac_code_t chan_code [`N_CHAN];
	logic [`N_CHAN-1:0] chan_code_valid;

	// queue to serial driver
	logic issue;
	dac_pkg::dac_code_t issue_code;
	logic [`W_CHAN_SEL-1:0] issue_chan;
	logic serial_done;

	////////////////////////////////////////
	// config and routing
	////////////////////////////////////////

	chan_router u_router (
		.clk50_in      (clk50_in),
		.sys_reset     (sys_reset),
		.cfg_write     (cfg_write),
		.cfg_addr      (cfg_addr),
		.cfg_chan      (cfg_chan),
		.cfg_data      (cfg_data),
		.adc_data_a    (adc_data_a),
		.adc_data_b    (adc_data_b),
		.adc_valid     (adc_valid),
		.chan_sample   (chan_sample),
		.chan_valid    (chan_valid),
		.chan_osm      (chan_osm),
		.chan_setpoint (chan_setpoint),
		.chan_p_coef   (chan_p_coef),
		.chan_i_coef   (chan_i_coef),
		.chan_lock_en  (chan_lock_en),
		.chan_min      (chan_min),
		.chan_max      (chan_max),
		.chan_init     (chan_init),
		.chan_rs       (chan_rs)
	);

	// one pipeline per dac channel
	for (genvar i = 0; i < `N_CHAN; i++) begin : g_chan
		pid_channel u_chan (
			.clk50_in     (clk50_in),
			.sys_reset    (sys_reset),
			.sample       (chan_sample[i]),
			.sample_valid (chan_valid[i]),
			.osm          (chan_osm[i]),
			.setpoint     (chan_setpoint[i]),
			.p_coef       (chan_p_coef[i]),
			.i_coef       (chan_i_coef[i]),
			.lock_en      (chan_lock_en[i]),
			.code_min     (chan_min[i]),
			.code_max     (chan_max[i]),
			.code_init    (chan_init[i]),
			.rs           (chan_rs[i]),
			.code         (chan_code[i]),
			.code_valid   (chan_code_valid[i])
		);
	end

	////////////////////////////////////////
	// dac output
	////////////////////////////////////////

	dac_instr_queue u_queue (
		.clk50_in    (clk50_in),
		.sys_reset   (sys_reset),
		.code        (chan_code),
		.code_valid  (chan_code_valid),
		.serial_done (serial_done),
		.issue       (issue),
		.issue_code  (issue_code),
		.issue_chan  (issue_chan)
	);

	dac_serial u_serial (
		.clk50_in   (clk50_in),
		.sys_reset  (sys_reset),
		.issue      (issue),
		.issue_code (issue_code),
		.issue_chan (issue_chan),
		.sync       (dac_sync),
		.sclk       (dac_sclk),
		.din        (dac_din),
		.done       (serial_done)
	);

endmodule

// File: test/pid_controller_sva.sv
`include "pid_settings.svh"

module pid_controller_sva (
	input logic clk50_in,
	input logic sys_reset,
	input logic sync,
	input logic sclk,
	input logic din
);

	// two clock cycles per frame bit
	localparam logic [7:0] FRAME_CYCLES = 8'(2 * `W_FRAME);

	logic [7:0] low_cnt;

	// cycles spent with sync low in the current frame
	always_ff @(posedge clk50_in) begin
		if (sys_reset || sync)
			low_cnt <= '0;
		else
			low_cnt <= low_cnt + 1'b1;
	end

	////////////////////////////////////////
	// frame timing
	////////////////////////////////////////

	frame_len: assert property (@(posedge clk50_in) disable iff (sys_reset)
		$rose(sync) |-> low_cnt == FRAME_CYCLES)
		else $error("dac sync rose before or after one full frame");

	frame_max: assert property (@(posedge clk50_in) disable iff (sys_reset)
		!sync |-> low_cnt < FRAME_CYCLES)
		else $error("dac sync held low past the frame length");

	// bus idles with the clock low
	idle_sclk: assert property (@(posedge clk50_in) disable iff (sys_reset)
		sync |-> !sclk)
		else $error("dac sclk high while sync is high");

	// the dac samples din in the low half
	din_hold: assert property (@(posedge clk50_in) disable iff (sys_reset)
		(!sync && !sclk) |-> $stable(din))
		else $error("dac din changed during an sclk low cycle");

endmodule

bind dac_serial pid_controller_sva u_sva (
	.clk50_in  (clk50_in),
	.sys_reset (sys_reset),
	.sync      (sync),
	.sclk      (sclk),
	.din       (din)
);

// File: test/pid_controller_tb.sv
`include "pid_settings.svh"

module pid_controller_tb;

	logic clk50_in;
	logic sys_reset;
	logic cfg_write;
	pid_cfg_pkg::cfg_addr_t cfg_addr;
	logic [`W_CHAN_SEL-1:0] cfg_chan;
	logic [31:0] cfg_data;
	pid_cfg_pkg::sample_t adc_data_a;
	pid_cfg_pkg::sample_t adc_data_b;
	logic [`N_ADC-1:0] adc_valid;
	logic dac_sync;
	logic dac_sclk;
	logic dac_din;

	int errors;
	int checks;
	logic [31:0] lfsr;
	// decoded frames, oldest first
	logic [31:0] frame_q [$];
	logic [31:0] rx_bits;
	int rx_cnt;

	pid_controller u_dut (
		.clk50_in   (clk50_in),
		.sys_reset  (sys_reset),
		.cfg_write  (cfg_write),
		.cfg_addr   (cfg_addr),
		.cfg_chan   (cfg_chan),
		.cfg_data   (cfg_data),
		.adc_data_a (adc_data_a),
		.adc_data_b (adc_data_b),
		.adc_valid  (adc_valid),
		.dac_sync   (dac_sync),
		.dac_sclk   (dac_sclk),
		.dac_din    (dac_din)
	);

	initial begin
		clk50_in = 1'b0;
		forever #10 clk50_in = ~clk50_in;
	end

	////////////////////////////////////////
	// dac frame monitor
	////////////////////////////////////////

	// din is taken in the sclk low half, msb first
	always @(negedge clk50_in) begin
		if (dac_sync !== 1'b0) begin
			rx_cnt = 0;
		end else if (dac_sclk === 1'b0) begin
			rx_bits = {rx_bits[30:0], dac_din};
			rx_cnt++;
			if (rx_cnt == `W_FRAME) begin
				frame_q.push_back(rx_bits);
				rx_cnt = 0;
			end
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// 12 bit signed sample, keeps the p+i sum well inside the code range
	function automatic logic signed [15:0] rand_sample();
		logic [31:0] r;
		r = rand_bits(12);
		return {{4{r[11]}}, r[11:0]};
	endfunction

	// output rule: offset plus shifted sum, clamped with unsigned bounds
	function automatic logic [15:0] clamp_code(input longint pi_sum, input int rs,
		input longint init, input longint lo, input longint hi);
		longint val;
		val = init + (pi_sum >>> rs);
		if (val < lo)
			return lo[15:0];
		else if (val > hi)
			return hi[15:0];
		return val[15:0];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			$display("Fail %s exp=%h got=%h", name, exp, got);
			errors++;
		end
	endtask

	// inputs change 2 units after the rising edge
	task automatic drive_slot();
		@(posedge clk50_in);
		#2;
	endtask

	task automatic write_cfg(input pid_cfg_pkg::cfg_addr_t addr, input int chan, input int data);
		drive_slot();
		cfg_write = 1'b1;
		cfg_addr = addr;
		cfg_chan = `W_CHAN_SEL'(chan);
		cfg_data = data;
		drive_slot();
		cfg_write = 1'b0;
	endtask

	task automatic configure_channel(input int ch, input int src, input int osm,
		input int setpoint, input int p, input int i, input int rs, input int init,
		input int lo, input int hi, input int lock, input int active);
		write_cfg(pid_cfg_pkg::src_sel, ch, src);
		write_cfg(pid_cfg_pkg::osf_osm, ch, osm);
		write_cfg(pid_cfg_pkg::pid_setpoint, ch, setpoint);
		write_cfg(pid_cfg_pkg::pid_p_coef, ch, p);
		write_cfg(pid_cfg_pkg::pid_i_coef, ch, i);
		write_cfg(pid_cfg_pkg::opp_rs, ch, rs);
		write_cfg(pid_cfg_pkg::opp_init, ch, init);
		write_cfg(pid_cfg_pkg::opp_min, ch, lo);
		write_cfg(pid_cfg_pkg::opp_max, ch, hi);
		write_cfg(pid_cfg_pkg::pid_lock_en, ch, lock);
		write_cfg(pid_cfg_pkg::chan_activate, ch, active);
	endtask

	// one strobe on a single source, then a quiet cycle
	task automatic drive_sample(input int src, input logic signed [15:0] a_val,
		input logic signed [15:0] b_val);
		drive_slot();
		adc_data_a = a_val;
		adc_data_b = b_val;
		adc_valid = `N_ADC'(1 << src);
		drive_slot();
		adc_valid = '0;
	endtask

	task automatic pulse_all_sources(input int n);
		repeat (n) begin
			drive_slot();
			adc_data_a = rand_sample();
			adc_data_b = rand_sample();
			adc_valid = '1;
			drive_slot();
			adc_valid = '0;
		end
	endtask

	task automatic wait_frames(input int n);
		int cycles;
		cycles = 0;
		while (frame_q.size() < n && cycles < 2000) begin
			@(posedge clk50_in);
			cycles++;
		end
		if (frame_q.size() < n) begin
			$display("timeout after %0d cycles waiting for %0d DAC frames", cycles, n);
			errors++;
		end
	endtask

	// fixed idle window, then no frame may be left over
	task automatic expect_silence(input int cycles);
		repeat (cycles) @(posedge clk50_in);
		check_val("frame_count", 0, frame_q.size());
	endtask

	task automatic check_frame(input int chan, input logic [15:0] code);
		logic [31:0] f;
		if (frame_q.size() == 0) begin
			$display("no DAC frame available to check for channel %0d", chan);
			errors++;
		end else begin
			f = frame_q.pop_front();
			// prefix, command, address, data, feature
			check_val("frame_prefix", 0, f[31:28]);
			check_val("frame_cmd", 3, f[27:24]);
			check_val("frame_addr", chan, f[23:20]);
			check_val("frame_code", code, f[19:4]);
			check_val("frame_feature", 0, f[3:0]);
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic reset_state_idle();
		check_val("dac_sync", 1, dac_sync);
		check_val("dac_sclk", 0, dac_sclk);
		check_val("dac_din", 0, dac_din);
		// nothing active, so strobes must not reach the dac
		pulse_all_sources(50);
		expect_silence(100);
	endtask

	task automatic unlocked_output();
		frame_q.delete();
		configure_channel(2, 1, 1, 0, 0, 0, 0, 'h1234, 0, 0, 0, 1);
		drive_sample(1, rand_sample(), rand_sample());
		drive_sample(1, rand_sample(), rand_sample());
		wait_frames(1);
		check_frame(2, 16'h1234);
		expect_silence(100);
		write_cfg(pid_cfg_pkg::chan_activate, 2, 0);
	endtask

	task automatic pi_lock_average();
		logic signed [15:0] v;
		longint total;
		longint err;
		longint integ;
		integ = 0;
		frame_q.delete();
		configure_channel(0, 0, 2, 1000, 2, 1, 1, 'h8000, 0, 'hffff, 1, 1);
		for (int g = 0; g < 2; g++) begin
			total = 0;
			for (int k = 0; k < 4; k++) begin
				v = rand_sample();
				total += v;
				drive_sample(0, v, ~v);
			end
			// mean of four, then error against the setpoint
			err = 1000 - (total >>> 2);
			integ += err;
			wait_frames(1);
			check_frame(0, clamp_code(2 * err + integ, 1, 'h8000, 0, 'hffff));
		end
		expect_silence(100);
		write_cfg(pid_cfg_pkg::chan_activate, 0, 0);
	endtask

	task automatic output_clamp();
		longint err;
		frame_q.delete();
		configure_channel(5, 2, 0, 0, 100, 0, 0, 'h8000, 'h1000, 'he000, 1, 1);
		// big positive error drives the output over the top
		drive_sample(2, -16'sd30000, 16'sd0);
		err = 30000;
		wait_frames(1);
		check_frame(5, clamp_code(100 * err, 0, 'h8000, 'h1000, 'he000));
		// big negative error goes below zero
		drive_sample(2, 16'sd30000, 16'sd0);
		err = -30000;
		wait_frames(1);
		check_frame(5, clamp_code(100 * err, 0, 'h8000, 'h1000, 'he000));
		expect_silence(100);
		write_cfg(pid_cfg_pkg::chan_activate, 5, 0);
	endtask

	task automatic source_routing();
		frame_q.delete();
		configure_channel(3, 5, 0, 0, 1, 0, 0, 'h4000, 0, 'hffff, 1, 1);
		// bus a carries a decoy value
		drive_sample(5, 16'sh0700, 16'sh0100);
		wait_frames(1);
		check_frame(3, clamp_code(-256, 0, 'h4000, 0, 'hffff));
		expect_silence(100);
		write_cfg(pid_cfg_pkg::chan_activate, 3, 0);
		// invalid source on an active channel, valid source on an idle one
		configure_channel(4, 9, 0, 0, 1, 0, 0, 'h2000, 0, 'hffff, 0, 1);
		configure_channel(7, 6, 0, 0, 1, 0, 0, 'h3000, 0, 'hffff, 0, 0);
		pulse_all_sources(8);
		expect_silence(200);
	endtask

	task automatic queue_order();
		frame_q.delete();
		configure_channel(6, 3, 0, 0, 0, 0, 0, 'h6666, 0, 0, 0, 1);
		configure_channel(1, 3, 0, 0, 0, 0, 0, 'h1111, 0, 0, 0, 1);
		// shared source, both groups end on the same edge
		drive_sample(3, rand_sample(), rand_sample());
		wait_frames(2);
		check_frame(1, 16'h1111);
		check_frame(6, 16'h6666);
		expect_silence(100);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		errors = 0;
		checks = 0;
		lfsr = 32'hb92e_d5d2;
		sys_reset = 1'b1;
		cfg_write = 1'b0;
		cfg_addr = pid_cfg_pkg::chan_activate;
		cfg_chan = '0;
		cfg_data = '0;
		adc_data_a = '0;
		adc_data_b = '0;
		adc_valid = '0;
		repeat (3) @(posedge clk50_in);
		#2;
		sys_reset = 1'b0;
		reset_state_idle();
		unlocked_output();
		pi_lock_average();
		output_clamp();
		source_routing();
		queue_order();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: tb.f
+incdir+hdl
hdl/pid_cfg_pkg.sv
hdl/dac_pkg.sv
hdl/chan_router.sv
hdl/pid_channel.sv
hdl/dac_instr_queue.sv
hdl/dac_serial.sv
hdl/pid_controller.sv
test/pid_controller_sva.sv
test/pid_controller_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module pid_controller_tb

out=$(./obj_dir/Vpid_controller_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TB PASSED"; then
	exit 0
fi
exit 1
